//--- src/vfu_consts.svh
`ifndef VFU_CONSTS_SVH
`define VFU_CONSTS_SVH

// lane count, must stay at 9 or more for the 3x3 permutations.
`define VFU_LANES 16

// single-precision word.
`define VFU_DATA_WIDTH 32

// opcode codes.
`define VFU_MIN    5'd0
`define VFU_MAX    5'd1
`define VFU_EQ     5'd2
`define VFU_LT     5'd3
`define VFU_LE     5'd4
`define VFU_SGNJ   5'd5
`define VFU_SGNJN  5'd6
`define VFU_SGNJX  5'd7
`define VPERMUTE   5'd8

// funct codes.
`define VFU_FUNCT_SKEW      3'd0
`define VFU_FUNCT_TRANSPOSE 3'd1
`define VFU_FUNCT_BCAST     3'd5

// quiet NaN returned by min/max when both operands are NaN.
`define VFU_CANON_NAN 32'h7fc0_0000

`endif

//--- src/vfu_pkg.sv
`default_nettype none

`include "vfu_consts.svh"

package vfu_pkg;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] mant;
    } fp_fields_t;

    // same word seen as raw bits or as ieee fields.
    typedef union packed {
        logic [`VFU_DATA_WIDTH-1:0] bits;
        fp_fields_t                 f;
    } fp_word_u;

    typedef fp_word_u [`VFU_LANES-1:0] fp_vec_t;

    typedef enum logic [3:0] {
        SEL_MIN,
        SEL_MAX,
        SEL_EQ,
        SEL_LT,
        SEL_LE,
        SEL_SGNJ,
        SEL_SGNJN,
        SEL_SGNJX,
        SEL_PERM,
        SEL_ZERO
    } result_sel_e;

    typedef enum logic [1:0] {
        PERM_SKEW,
        PERM_TRANSPOSE,
        PERM_NONE
    } perm_mode_e;

    typedef struct packed {
        result_sel_e sel;
        perm_mode_e  perm;
        logic        bcast;
        logic        load;
    } vfu_ctrl_t;

endpackage

`default_nettype wire

//--- src/vfu_ctrl.sv
`default_nettype none

`include "vfu_consts.svh"

module vfu_ctrl
    import vfu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic [4:0] opcode,
    input  logic [2:0] funct,
    output vfu_ctrl_t  ctrl,
    output logic       out_valid
);

    result_sel_e sel;
    perm_mode_e  perm;

    always_comb begin
        sel  = SEL_ZERO;
        perm = PERM_NONE;
        case (opcode)
            `VFU_MIN:   sel = SEL_MIN;
            `VFU_MAX:   sel = SEL_MAX;
            `VFU_EQ:    sel = SEL_EQ;
            `VFU_LT:    sel = SEL_LT;
            `VFU_LE:    sel = SEL_LE;
            `VFU_SGNJ:  sel = SEL_SGNJ;
            `VFU_SGNJN: sel = SEL_SGNJN;
            `VFU_SGNJX: sel = SEL_SGNJX;
            `VPERMUTE: begin
                case (funct)
                    `VFU_FUNCT_SKEW: begin
                        sel  = SEL_PERM;
                        perm = PERM_SKEW;
                    end
                    `VFU_FUNCT_TRANSPOSE: begin
                        sel  = SEL_PERM;
                        perm = PERM_TRANSPOSE;
                    end
                    default: sel = SEL_ZERO;
                endcase
            end
            default: sel = SEL_ZERO;
        endcase
    end

    // broadcast only makes sense for the per-lane operations.
    assign ctrl.sel   = sel;
    assign ctrl.perm  = perm;
    assign ctrl.bcast = (funct == `VFU_FUNCT_BCAST) && (sel != SEL_PERM) && (sel != SEL_ZERO);
    assign ctrl.load  = en;

    // result lands one edge after en, so valid is just en delayed.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= en;
        end
    end

endmodule

`default_nettype wire

//--- src/vfu_permute.sv
`default_nettype none

`include "vfu_consts.svh"

module vfu_permute
    import vfu_pkg::*;
(
    input  fp_vec_t    vec_a,
    input  perm_mode_e perm,
    output fp_vec_t    perm_vec
);

    fp_word_u [8:0] skew;
    fp_word_u [8:0] trans;

    function automatic fp_word_u negate(input fp_word_u w);
        fp_word_u r;
        r        = w;
        r.f.sign = ~w.f.sign;
        return r;
    endfunction

    // cross-product matrix of the vector in lanes 0..2.
    assign skew[0] = '0;
    assign skew[1] = vec_a[2];
    assign skew[2] = negate(vec_a[1]);
    assign skew[3] = negate(vec_a[2]);
    assign skew[4] = '0;
    assign skew[5] = vec_a[0];
    assign skew[6] = vec_a[1];
    assign skew[7] = negate(vec_a[0]);
    assign skew[8] = '0;

    for (genvar i = 0; i < 3; i++) begin : g_row
        for (genvar j = 0; j < 3; j++) begin : g_col
            assign trans[3*i+j] = vec_a[3*j+i];
        end
    end

    // upper lanes stay zero for both layouts.
    always_comb begin
        perm_vec = '0;
        case (perm)
            PERM_SKEW:      perm_vec[8:0] = skew;
            PERM_TRANSPOSE: perm_vec[8:0] = trans;
            default:        perm_vec = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/vfu_lane.sv
`default_nettype none

`include "vfu_consts.svh"

module vfu_lane
    import vfu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  vfu_ctrl_t ctrl,
    input  fp_word_u  a,
    input  fp_word_u  b,
    input  fp_word_u  perm_word,
    output fp_word_u  result
);

    logic     a_nan;
    logic     b_nan;
    logic     unordered;
    logic     both_zero;
    logic     mag_lt;
    logic     mag_gt;
    logic     aeqb;
    logic     altb;
    fp_word_u min_w;
    fp_word_u max_w;
    fp_word_u sgnj;
    fp_word_u sgnjn;
    fp_word_u sgnjx;
    fp_word_u sel_w;

    assign a_nan     = (a.f.exp == 8'hff) && (a.f.mant != '0);
    assign b_nan     = (b.f.exp == 8'hff) && (b.f.mant != '0);
    assign unordered = a_nan | b_nan;
    assign both_zero = (a.bits[30:0] == '0) && (b.bits[30:0] == '0);

    // exponent sits above mantissa, so the low 31 bits order as an integer.
    assign mag_lt = a.bits[30:0] < b.bits[30:0];
    assign mag_gt = a.bits[30:0] > b.bits[30:0];

    assign aeqb = !unordered && ((a.bits == b.bits) || both_zero);

    always_comb begin
        altb = 1'b0;
        if (!unordered && !both_zero) begin
            if (a.f.sign != b.f.sign) begin
                altb = a.f.sign;
            end else if (a.f.sign) begin
                altb = mag_gt;
            end else begin
                altb = mag_lt;
            end
        end
    end

    always_comb begin
        if (a_nan && b_nan) begin
            min_w.bits = `VFU_CANON_NAN;
            max_w.bits = `VFU_CANON_NAN;
        end else if (a_nan) begin
            min_w = b;
            max_w = b;
        end else if (b_nan) begin
            min_w = a;
            max_w = a;
        end else if (both_zero && (a.f.sign != b.f.sign)) begin
            min_w.bits = {1'b1, 31'b0};
            max_w.bits = '0;
        end else begin
            // ties go to a.
            min_w = (altb || aeqb) ? a : b;
            max_w = altb ? b : a;
        end
    end

    // magnitude always from a.
    assign sgnj.bits  = {b.f.sign, a.bits[30:0]};
    assign sgnjn.bits = {~b.f.sign, a.bits[30:0]};
    assign sgnjx.bits = {a.f.sign ^ b.f.sign, a.bits[30:0]};

    always_comb begin
        case (ctrl.sel)
            SEL_MIN:   sel_w = min_w;
            SEL_MAX:   sel_w = max_w;
            SEL_EQ:    sel_w.bits = {31'b0, aeqb};
            SEL_LT:    sel_w.bits = {31'b0, altb};
            SEL_LE:    sel_w.bits = {31'b0, aeqb | altb};
            SEL_SGNJ:  sel_w = sgnj;
            SEL_SGNJN: sel_w = sgnjn;
            SEL_SGNJX: sel_w = sgnjx;
            SEL_PERM:  sel_w = perm_word;
            default:   sel_w = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (ctrl.load) begin
            result <= sel_w;
        end
    end

endmodule

`default_nettype wire

//--- src/vfu_top.sv
`default_nettype none

`include "vfu_consts.svh"

module vfu_top
    import vfu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  fp_vec_t    vec_a,
    input  fp_vec_t    vec_b,
    input  logic [4:0] opcode,
    input  logic [2:0] funct,
    output fp_vec_t    vec_out,
    output logic       out_valid
);

    vfu_ctrl_t ctrl;
    fp_vec_t   perm_vec;

    vfu_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .opcode    (opcode),
        .funct     (funct),
        .ctrl      (ctrl),
        .out_valid (out_valid)
    );

    vfu_permute u_perm (
        .vec_a    (vec_a),
        .perm     (ctrl.perm),
        .perm_vec (perm_vec)
    );

    // broadcast feeds lane 0 of a to every lane.
    for (genvar i = 0; i < `VFU_LANES; i++) begin : g_lane
        vfu_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .ctrl      (ctrl),
            .a         (ctrl.bcast ? vec_a[0] : vec_a[i]),
            .b         (vec_b[i]),
            .perm_word (perm_vec[i]),
            .result    (vec_out[i])
        );
    end

endmodule

`default_nettype wire

//--- dv/vfu_assertions.sv
`default_nettype none

module vfu_assertions (
    input logic clk,
    input logic rst_n,
    input logic en,
    input logic out_valid
);

    property p_idle_in_reset;
        @(posedge clk) !rst_n |-> !out_valid;
    endproperty

    // valid is en delayed by exactly one edge.
    property p_valid_after_en;
        @(posedge clk) disable iff (!rst_n) en |=> out_valid;
    endproperty

    property p_no_valid_without_en;
        @(posedge clk) disable iff (!rst_n) !en |=> !out_valid;
    endproperty

    a_idle_in_reset: assert property (p_idle_in_reset)
        else $error("out_valid high during reset");

    a_valid_after_en: assert property (p_valid_after_en)
        else $error("out_valid missing one cycle after en");

    a_no_valid_without_en: assert property (p_no_valid_without_en)
        else $error("out_valid without a preceding en");

endmodule

bind vfu_ctrl vfu_assertions u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .out_valid (out_valid)
);

`default_nettype wire

//--- dv/vfu_checker.sv
`default_nettype none

`include "vfu_consts.svh"

module vfu_checker
    import vfu_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    out_valid,
    input fp_vec_t vec_out
);

    fp_vec_t expected_q[$];
    int      mismatch_count = 0;
    int      unexpected_count = 0;
    int      results_seen = 0;
    logic    reset_checked = 1'b0;

    task automatic push_expected(input fp_vec_t v);
        expected_q.push_back(v);
    endtask

    function automatic int pending();
        return expected_q.size();
    endfunction

    function automatic int total_errors();
        return mismatch_count + unexpected_count;
    endfunction

    task automatic compare_result(input fp_vec_t exp_v);
        for (int i = 0; i < `VFU_LANES; i++) begin
            if (vec_out[i].bits !== exp_v[i].bits) begin
                if (exp_v[i].bits == `VFU_CANON_NAN) begin
                    $display("** Error at time %0t: lane %0d expected canonical NaN %h actual %h",
                             $time, i, exp_v[i].bits, vec_out[i].bits);
                end else begin
                    $display("** Error at time %0t: lane %0d expected %h actual %h",
                             $time, i, exp_v[i].bits, vec_out[i].bits);
                end
                mismatch_count++;
            end
        end
    endtask

    // first edge out of reset must see a cleared unit.
    always @(posedge clk) begin
        if (rst_n && !reset_checked) begin
            reset_checked <= 1'b1;
            if (out_valid !== 1'b0 || vec_out !== '0) begin
                $display("** Error at time %0t: unit not idle and cleared after reset", $time);
                mismatch_count++;
            end
        end else if (rst_n && out_valid === 1'b1) begin
            results_seen++;
            if (expected_q.size() == 0) begin
                $display("unexpected result at time %0t with no vector outstanding", $time);
                unexpected_count++;
            end else begin
                compare_result(expected_q.pop_front());
            end
        end
    end

    task automatic report(input int other_errors);
        $display("results=%0d mismatch errors=%0d unexpected results=%0d other errors=%0d",
                 results_seen, mismatch_count, unexpected_count, other_errors);
    endtask

endmodule

`default_nettype wire

//--- dv/vfu_tb.sv
`default_nettype none

`include "vfu_consts.svh"

module vfu_tb
    import vfu_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       en;
    fp_vec_t    vec_a;
    fp_vec_t    vec_b;
    logic [4:0] opcode;
    logic [2:0] funct;
    fp_vec_t    vec_out;
    logic       out_valid;

    logic [31:0] rng_state;
    int          other_errors;

    localparam int VEC_BITS = $bits(fp_vec_t);

    vfu_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .vec_a     (vec_a),
        .vec_b     (vec_b),
        .opcode    (opcode),
        .funct     (funct),
        .vec_out   (vec_out),
        .out_valid (out_valid)
    );

    vfu_checker u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .vec_out   (vec_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic is_blank(input logic [7:0] ch);
        return (ch == " ") || (ch == "\t") || (ch == "\n") || (ch == "\r");
    endfunction

    // value of one hex digit, or -1 for any other character.
    function automatic int hex_value(input logic [7:0] ch);
        int v;
        v = -1;
        if (ch >= "0" && ch <= "9") begin
            v = ch - "0";
        end else if (ch >= "a" && ch <= "f") begin
            v = ch - "a" + 10;
        end else if (ch >= "A" && ch <= "F") begin
            v = ch - "A" + 10;
        end
        return v;
    endfunction

    // one compare flag per lane in bit 0 of its word.
    function automatic fp_vec_t flags_to_vec(input logic [`VFU_LANES-1:0] m);
        fp_vec_t v;
        v = '0;
        for (int i = 0; i < `VFU_LANES; i++) begin
            v[i].bits[0] = m[i];
        end
        return v;
    endfunction

    // one strobe per call, so consecutive calls give back-to-back en.
    task automatic drive_vector(input logic [4:0] op, input logic [2:0] fn,
                                input fp_vec_t a, input fp_vec_t b, input fp_vec_t e);
        @(posedge clk);
        en     <= 1'b1;
        opcode <= op;
        funct  <= fn;
        vec_a  <= a;
        vec_b  <= b;
        u_chk.push_expected(e);
    endtask

    task automatic run_file(input int fd);
        string                 line;
        int                    n;
        int                    tokens;
        int                    digits;
        int                    v;
        logic                  in_token;
        logic                  bad;
        logic [31:0]           op_w;
        logic [31:0]           fn_w;
        logic [3*VEC_BITS-1:0] payload;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                tokens   = 0;
                digits   = 0;
                in_token = 1'b0;
                bad      = 1'b0;
                op_w     = '0;
                fn_w     = '0;
                payload  = '0;
                // the three vectors may be split by blanks at any digit.
                for (int c = 0; c < line.len(); c++) begin
                    if (is_blank(line[c])) begin
                        in_token = 1'b0;
                    end else begin
                        if (!in_token) begin
                            tokens++;
                        end
                        in_token = 1'b1;
                        v = hex_value(line[c]);
                        if (v < 0) begin
                            bad = 1'b1;
                        end else if (tokens == 1) begin
                            op_w = {op_w[27:0], v[3:0]};
                        end else if (tokens == 2) begin
                            fn_w = {fn_w[27:0], v[3:0]};
                        end else begin
                            payload = {payload[3*VEC_BITS-5:0], v[3:0]};
                            digits++;
                        end
                    end
                end
                if (tokens != 0) begin
                    if (bad || digits != 3*VEC_BITS/4) begin
                        $display("input file line could not be parsed: %s", line);
                        other_errors++;
                    end else begin
                        drive_vector(op_w[4:0], fn_w[2:0],
                                     payload[3*VEC_BITS-1 -: VEC_BITS],
                                     payload[2*VEC_BITS-1 -: VEC_BITS],
                                     payload[VEC_BITS-1:0]);
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_directed();
        fp_vec_t a_v;
        fp_vec_t b_v;
        fp_vec_t pa;
        fp_vec_t e_v;
        int      tr_src[9];
        // lane 15 first, covering ordering, signed zeros, NaNs and infinities.
        a_v = {32'h1234_5678, 32'h3f00_0000, 32'hc040_0000, 32'h0000_0001,
               32'hff80_0000, 32'h7f80_0000, 32'h4040_0000, 32'h7fc0_0000,
               32'h4040_0000, 32'h7fc0_0001, 32'h8000_0000, 32'h0000_0000,
               32'hc000_0000, 32'hbf80_0000, 32'h4000_0000, 32'h3f80_0000};
        b_v = {32'h9234_5678, 32'hbf00_0000, 32'h4040_0000, 32'h0000_0002,
               32'h0000_0001, 32'h4040_0000, 32'h4040_0000, 32'hffc0_0000,
               32'h7f80_0001, 32'h3f80_0000, 32'h0000_0000, 32'h8000_0000,
               32'hbf80_0000, 32'h3f80_0000, 32'h3f80_0000, 32'h4000_0000};
        drive_vector(`VFU_EQ, 3'd0, a_v, b_v, flags_to_vec(16'h0230));
        drive_vector(`VFU_LT, 3'd0, a_v, b_v, flags_to_vec(16'h380d));
        drive_vector(`VFU_LE, 3'd0, a_v, b_v, flags_to_vec(16'h3a3d));

        // lane 0 of a is 1.0, so every lane compares 1.0 against b.
        drive_vector(`VFU_LT, `VFU_FUNCT_BCAST, a_v, b_v, flags_to_vec(16'h2601));
        for (int i = 0; i < `VFU_LANES; i++) begin
            e_v[i].bits = {b_v[i].bits[31], 31'h3f80_0000};
        end
        drive_vector(`VFU_SGNJ, `VFU_FUNCT_BCAST, a_v, b_v, e_v);

        for (int i = 0; i < `VFU_LANES; i++) begin
            pa[i].bits = 32'h3f80_0000 + i;
        end
        pa[1].bits[31] = 1'b1;

        e_v = '0;
        e_v[1].bits = 32'h3f80_0002;
        e_v[2].bits = 32'h3f80_0001;
        e_v[3].bits = 32'hbf80_0002;
        e_v[5].bits = 32'h3f80_0000;
        e_v[6].bits = 32'hbf80_0001;
        e_v[7].bits = 32'hbf80_0000;
        drive_vector(`VPERMUTE, `VFU_FUNCT_SKEW, pa, b_v, e_v);

        // source lane of each output lane for a row-major 3x3 matrix.
        tr_src = '{0, 3, 6, 1, 4, 7, 2, 5, 8};
        e_v = '0;
        for (int i = 0; i < 9; i++) begin
            e_v[i] = pa[tr_src[i]];
        end
        drive_vector(`VPERMUTE, `VFU_FUNCT_TRANSPOSE, pa, b_v, e_v);

        drive_vector(`VPERMUTE, 3'd2, pa, b_v, '0);
        drive_vector(5'd20, 3'd0, a_v, b_v, '0);
    endtask

    task automatic run_random();
        fp_vec_t    a_v;
        fp_vec_t    b_v;
        fp_vec_t    e_v;
        logic [4:0] op;
        logic       sgn;
        for (int k = 0; k < 20; k++) begin
            rng_state = xorshift32(rng_state);
            case (rng_state % 3)
                0: op = `VFU_SGNJ;
                1: op = `VFU_SGNJN;
                default: op = `VFU_SGNJX;
            endcase
            for (int i = 0; i < `VFU_LANES; i++) begin
                rng_state = xorshift32(rng_state);
                a_v[i].bits = rng_state;
                rng_state = xorshift32(rng_state);
                b_v[i].bits = rng_state;
                // sign from the rule, magnitude always from a.
                if (op == `VFU_SGNJ) begin
                    sgn = b_v[i].bits[31];
                end else if (op == `VFU_SGNJN) begin
                    sgn = ~b_v[i].bits[31];
                end else begin
                    sgn = a_v[i].bits[31] ^ b_v[i].bits[31];
                end
                e_v[i].bits = {sgn, a_v[i].bits[30:0]};
            end
            drive_vector(op, 3'd0, a_v, b_v, e_v);
        end
    endtask

    task automatic drain_results();
        int wait_cycles;
        wait_cycles = 0;
        while (u_chk.pending() != 0 && wait_cycles < 100) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (u_chk.pending() != 0) begin
            $display("timed out waiting for %0d outstanding results", u_chk.pending());
            other_errors++;
        end
    endtask

    task automatic finish_run();
        u_chk.report(other_errors);
        if (u_chk.total_errors() + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        int fd;
        rst_n        = 1'b0;
        en           = 1'b0;
        vec_a        = '0;
        vec_b        = '0;
        opcode       = '0;
        funct        = '0;
        rng_state    = 32'h35d5_c20d;
        other_errors = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        fd = $fopen("dv/vfu_input.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/vfu_input.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            run_file(fd);
            run_directed();
            run_random();
            @(posedge clk);
            en <= 1'b0;
            drain_results();
            finish_run();
        end
    end

endmodule

`default_nettype wire

//--- dv/vfu_input.txt
# opcode funct vec_a vec_b expected, all hex
# vectors are 16 words each, lane 15 first and lane 0 last
00 0 123456783f000000c040000000000001ff8000007f800000404000007fc00000404000007fc00001800000000000000 0c0000000bf800000400000003f800000 923456 78bf000000404000000000000200000001404000004040000 0ffc000007f8000013f800000000000008000000 0bf8000003f8000003f80000040000000 92345678bf000000c040000000000001ff80000040400000404000007fc00000404000003f800000800000008000000 0c0000000bf8000003f8000003f800000
01 0 123456783f000000c040000000000001ff8000007f800000404000007fc00000404000007fc00001800000000000000 0c0000000bf800000400000003f800000 92345678bf000000404000000000000200000001404000004040000 0ffc000007f8000013f800000000000008000000 0bf8000003f8000003f80000040000000 123456783f000000404000000000000200000001 7f800000404000007fc00000404000003f800000000000000000000 0bf8000003f8000004000000040000000

//--- verilog.f
+incdir+src
src/vfu_pkg.sv
src/vfu_ctrl.sv
src/vfu_permute.sv
src/vfu_lane.sv
src/vfu_top.sv
dv/vfu_assertions.sv
dv/vfu_checker.sv
dv/vfu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= vfu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert
PASS_TEXT ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
